// File: verilog/execPkg.sv
`default_nettype none

package execPkg;

        ////////////////////////////////////////////////////////////////////
        // Widths
        ////////////////////////////////////////////////////////////////////

        localparam int dataWidth    = 32;
        localparam int regAddrWidth = 5;
        localparam int immWidth     = 16;
        localparam int opWidth      = 4;
        localparam int numRegs      = 1 << regAddrWidth;

        // Shift amount taken from the low bits of the second operand
        localparam int shamtWidth   = $clog2(dataWidth);

        ////////////////////////////////////////////////////////////////////
        // Operations
        ////////////////////////////////////////////////////////////////////

        // Codes 10 to 15 are undefined and write zero
        typedef enum logic [opWidth-1:0] {
                OP_ADD  = 4'd0,
                OP_SUB  = 4'd1,
                OP_AND  = 4'd2,
                OP_OR   = 4'd3,
                OP_SRL  = 4'd4,
                OP_SRA  = 4'd5,
                OP_SLT  = 4'd6,
                OP_SLTU = 4'd7,
                OP_BEQ  = 4'd8,
                OP_LI   = 4'd9
        } opCode_t;

        // Decoded instruction as issued to the slice
        typedef struct packed {
                opCode_t                 op;
                logic [regAddrWidth-1:0] rd;
                logic [regAddrWidth-1:0] rs;
                logic [regAddrWidth-1:0] rt;
                logic [immWidth-1:0]     imm;
        } instr_t;

        // Register file write port
        typedef struct packed {
                logic                    en;
                logic [regAddrWidth-1:0] addr;
                logic [dataWidth-1:0]    data;
        } regWrite_t;

        // One writeback result per instruction
        typedef struct packed {
                logic                    valid;
                logic [regAddrWidth-1:0] dest;
                logic [dataWidth-1:0]    data;
                logic                    wrote;
                logic                    taken;
        } wbResult_t;

endpackage

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile
        import execPkg::*;
(
        input  logic                    clk,
        input  logic                    reset,
        input  logic [regAddrWidth-1:0] rsAddr,
        input  logic [regAddrWidth-1:0] rtAddr,
        output logic [dataWidth-1:0]    rsData,
        output logic [dataWidth-1:0]    rtData,
        input  regWrite_t               wr
);

        ////////////////////////////////////////////////////////////////////
        // Storage
        ////////////////////////////////////////////////////////////////////

        logic [dataWidth-1:0] regs [numRegs];

        // Register zero is cleared by reset and never written after
        logic writeOk;

        assign writeOk = wr.en && (wr.addr != '0);

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < numRegs; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeOk) begin
                        regs[wr.addr] <= wr.data;
                end
        end

        ////////////////////////////////////////////////////////////////////
        // Read ports
        ////////////////////////////////////////////////////////////////////

        // Combinational, so the next instruction sees a write
        // committed at this edge
        assign rsData = regs[rsAddr];
        assign rtData = regs[rtAddr];

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
        import execPkg::*;
(
        input  opCode_t              op,
        input  logic [dataWidth-1:0] a,
        input  logic [dataWidth-1:0] b,
        output logic [dataWidth-1:0] c
);

        // Only the low five bits of b move the shifters
        logic [shamtWidth-1:0] shamt;

        logic [dataWidth-1:0] sum;
        logic [dataWidth-1:0] diff;
        logic [dataWidth-1:0] srlOut;
        logic [dataWidth-1:0] sraOut;

        assign shamt = b[shamtWidth-1:0];

        ////////////////////////////////////////////////////////////////////
        // Datapath
        ////////////////////////////////////////////////////////////////////

        // Wraparound arithmetic, carry and overflow dropped
        assign sum  = a + b;
        assign diff = a - b;

        assign srlOut = a >> shamt;

        // Sign fill from bit 31
        assign sraOut = $signed(a) >>> shamt;

        ////////////////////////////////////////////////////////////////////
        // Operation select
        ////////////////////////////////////////////////////////////////////

        always_comb begin
                case (op)
                        OP_ADD: begin
                                c = sum;
                        end
                        OP_SUB: begin
                                c = diff;
                        end
                        OP_AND: begin
                                c = a & b;
                        end
                        OP_OR: begin
                                c = a | b;
                        end
                        OP_SRL: begin
                                c = srlOut;
                        end
                        OP_SRA: begin
                                c = sraOut;
                        end
                        // Compare, load-immediate and undefined codes
                        default: begin
                                c = '0;
                        end
                endcase
        end

endmodule

`default_nettype wire

// File: verilog/compareUnit.sv
`timescale 1ns/1ps
`default_nettype none

module compareUnit
        import execPkg::*;
(
        input  opCode_t              op,
        input  logic [dataWidth-1:0] a,
        input  logic [dataWidth-1:0] b,
        output logic [dataWidth-1:0] setVal,
        output logic                 eq
);

        logic ltSigned;
        logic ltUnsigned;
        logic setBit;

        // Both orderings evaluated every cycle
        assign ltSigned   = $signed(a) < $signed(b);
        assign ltUnsigned = a < b;

        always_comb begin
                case (op)
                        OP_SLT: begin
                                setBit = ltSigned;
                        end
                        OP_SLTU: begin
                                setBit = ltUnsigned;
                        end
                        default: begin
                                setBit = 1'b0;
                        end
                endcase
        end

        // Set value is one or zero
        assign setVal = {{(dataWidth-1){1'b0}}, setBit};

        // Branch test, independent of op
        assign eq = (a == b);

endmodule

`default_nettype wire

// File: verilog/resultSelect.sv
`timescale 1ns/1ps
`default_nettype none

module resultSelect
        import execPkg::*;
(
        input  logic                 clk,
        input  logic                 reset,
        input  logic                 instValid,
        input  instr_t               inst,
        input  logic [dataWidth-1:0] aluData,
        input  logic [dataWidth-1:0] cmpData,
        input  logic                 eq,
        output regWrite_t            regWr,
        output wbResult_t            wb
);

        logic [dataWidth-1:0] immExt;
        logic [dataWidth-1:0] selData;
        logic                 isBranch;
        logic                 writeEn;
        wbResult_t            wbNext;

        ////////////////////////////////////////////////////////////////////
        // Value select
        ////////////////////////////////////////////////////////////////////

        assign immExt = {{(dataWidth-immWidth){inst.imm[immWidth-1]}}, inst.imm};

        always_comb begin
                case (inst.op)
                        OP_SLT, OP_SLTU: begin
                                selData = cmpData;
                        end
                        OP_LI: begin
                                selData = immExt;
                        end
                        OP_BEQ: begin
                                selData = '0;
                        end
                        // ALU codes and undefined codes
                        default: begin
                                selData = aluData;
                        end
                endcase
        end

        ////////////////////////////////////////////////////////////////////
        // Register write, same edge as the result
        ////////////////////////////////////////////////////////////////////

        assign isBranch = (inst.op == OP_BEQ);

        // No write for a branch or for register zero
        assign writeEn = instValid && !isBranch && (inst.rd != '0);

        assign regWr.en   = writeEn;
        assign regWr.addr = inst.rd;
        assign regWr.data = selData;

        // Idle cycles leave the whole result at zero
        always_comb begin
                wbNext = '0;
                if (instValid) begin
                        wbNext.valid = 1'b1;
                        wbNext.dest  = inst.rd;
                        wbNext.data  = selData;
                        wbNext.wrote = writeEn;
                        wbNext.taken = isBranch && eq;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        wb <= '0;
                end else begin
                        wb <= wbNext;
                end
        end

endmodule

`default_nettype wire

// File: verilog/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore
        import execPkg::*;
(
        input  logic      clk,
        input  logic      reset,
        input  logic      instValid,
        input  instr_t    inst,
        output wbResult_t wb
);

        logic [dataWidth-1:0] rsData;
        logic [dataWidth-1:0] rtData;
        logic [dataWidth-1:0] aluData;
        logic [dataWidth-1:0] cmpData;
        logic                 eq;
        regWrite_t            regWr;

        ////////////////////////////////////////////////////////////////////
        // Operand read
        ////////////////////////////////////////////////////////////////////

        regFile u_regFile (
                .clk    (clk),
                .reset  (reset),
                .rsAddr (inst.rs),
                .rtAddr (inst.rt),
                .rsData (rsData),
                .rtData (rtData),
                .wr     (regWr)
        );

        ////////////////////////////////////////////////////////////////////
        // Execute units, side by side
        ////////////////////////////////////////////////////////////////////

        alu u_alu (
                .op (inst.op),
                .a  (rsData),
                .b  (rtData),
                .c  (aluData)
        );

        compareUnit u_compareUnit (
                .op     (inst.op),
                .a      (rsData),
                .b      (rtData),
                .setVal (cmpData),
                .eq     (eq)
        );

        ////////////////////////////////////////////////////////////////////
        // Writeback
        ////////////////////////////////////////////////////////////////////

        // Drives the write port back into the register file
        resultSelect u_resultSelect (
                .clk       (clk),
                .reset     (reset),
                .instValid (instValid),
                .inst      (inst),
                .aluData   (aluData),
                .cmpData   (cmpData),
                .eq        (eq),
                .regWr     (regWr),
                .wb        (wb)
        );

endmodule

`default_nettype wire

// File: tests/execCore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module execCore_chk
        import execPkg::*;
(
        input logic      clk,
        input logic      reset,
        input logic      instValid,
        input wbResult_t wb,
        input regWrite_t regWr
);

        int failCount = 0;

        // One cycle from issue to result
        resultTiming: assert property (@(posedge clk) disable iff (reset)
                !$past(reset) |-> wb.valid == $past(instValid))
        else begin
                $error("wb.valid does not follow instValid by one cycle");
                failCount++;
        end

        // Whole result cleared by reset
        resetState: assert property (@(posedge clk) $past(reset) |-> wb == '0)
        else begin
                $error("wb is not zero after reset");
                failCount++;
        end

        zeroWrite: assert property (@(posedge clk) disable iff (reset)
                !(regWr.en && regWr.addr == '0))
        else begin
                $error("register write port enabled for register zero");
                failCount++;
        end

endmodule

`default_nettype wire

// File: tests/execCoreMonitor.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreMonitor
        import execPkg::*;
(
        input  logic       clk,
        input  logic       reset,
        input  logic       instValid,
        input  instr_t     inst,
        input  wbResult_t  wb,
        input  logic [3:0] testNum,
        input  logic       testEnd,
        output logic       busy,
        output int         errorCount,
        output int         checkCount
);

        logic [dataWidth-1:0] model [numRegs];
        wbResult_t            expected;
        logic                 armed = 1'b0;
        logic                 pending = 1'b0;
        int                   testErrors = 0;
        int                   testChecks = 0;

        initial begin
                busy = 1'b0;
                errorCount = 0;
                checkCount = 0;
        end

        // Expected result straight from the operation rules
        function automatic wbResult_t predict(input instr_t i, input logic [31:0] a,
                        input logic [31:0] b);
                wbResult_t r;
                logic [4:0] s;
                s = b[4:0];
                r = '0;
                r.valid = 1'b1;
                r.dest = i.rd;
                case (i.op)
                        OP_ADD: r.data = a + b;
                        OP_SUB: r.data = a - b;
                        OP_AND: r.data = a & b;
                        OP_OR: r.data = a | b;
                        OP_SRL: r.data = a >> s;
                        OP_SRA: r.data = (a >> s) | (a[31] ? ~(32'hffffffff >> s) : 32'h0);
                        // Offset binary turns the signed order into the unsigned one
                        OP_SLT: r.data = {31'b0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};
                        OP_SLTU: r.data = {31'b0, a < b};
                        OP_BEQ: r.taken = (a == b);
                        OP_LI: r.data = {{16{i.imm[15]}}, i.imm};
                        default: r.data = '0;
                endcase
                r.wrote = (i.op != OP_BEQ) && (i.rd != '0);
                return r;
        endfunction

        task automatic checkField(input string name, input logic [63:0] exp,
                        input logic [63:0] act);
                if (act !== exp) begin
                        $display("ERROR test %0d: %s expected %0h got %0h", testNum, name, exp, act);
                        testErrors++;
                        errorCount++;
                end
        endtask

        //////////////////////////////////////////////////////////////////////
        // Compare one cycle after issue
        //////////////////////////////////////////////////////////////////////

        always @(posedge clk) begin
                if (reset) begin
                        for (int r = 0; r < numRegs; r++) begin
                                model[r] = '0;
                        end
                        pending = 1'b0;
                        armed = 1'b1;
                end else if (armed) begin
                        if (pending) begin
                                testChecks++;
                                checkCount++;
                                if (wb.valid !== 1'b1) begin
                                        $display("test %0d: result missing one cycle after issue",
                                                testNum);
                                        testErrors++;
                                        errorCount++;
                                end else begin
                                        checkField("wb.dest", expected.dest, wb.dest);
                                        checkField("wb.data", expected.data, wb.data);
                                        checkField("wb.wrote", expected.wrote, wb.wrote);
                                        checkField("wb.taken", expected.taken, wb.taken);
                                end
                        end else if (wb.valid !== 1'b0) begin
                                $display("test %0d: result appeared with no instruction issued",
                                        testNum);
                                testErrors++;
                                errorCount++;
                        end else begin
                                checkField("wb", '0, wb);
                        end
                        // Operands come from the model before this edge's write
                        if (instValid) begin
                                expected = predict(inst, model[inst.rs], model[inst.rt]);
                                if (expected.wrote) begin
                                        model[inst.rd] = expected.data;
                                end
                        end
                        pending = instValid;
                end
                busy <= pending;
                if (testEnd) begin
                        $display("Test %0d: %0d results checked, %0d errors",
                                testNum, testChecks, testErrors);
                        testChecks = 0;
                        testErrors = 0;
                end
        end

endmodule

`default_nettype wire

// File: tests/execCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module execCore_tb
        import execPkg::*;
();

        logic                    clk;
        logic                    reset;
        logic                    instValid;
        instr_t                  inst;
        wbResult_t               wb;
        logic [3:0]              testNum;
        logic                    testEnd;
        logic                    busy;
        int                      errorCount;
        int                      checkCount;
        int                      seed;
        bit                      timedOut;
        logic [regAddrWidth-1:0] lastRd;

        execCore u_execCore (
                .clk       (clk),
                .reset     (reset),
                .instValid (instValid),
                .inst      (inst),
                .wb        (wb)
        );

        execCoreMonitor u_monitor (
                .clk        (clk),
                .reset      (reset),
                .instValid  (instValid),
                .inst       (inst),
                .wb         (wb),
                .testNum    (testNum),
                .testEnd    (testEnd),
                .busy       (busy),
                .errorCount (errorCount),
                .checkCount (checkCount)
        );

        bind execCore execCore_chk u_chk (
                .clk       (clk),
                .reset     (reset),
                .instValid (instValid),
                .wb        (wb),
                .regWr     (regWr)
        );

        always #4 clk = ~clk;

        function automatic logic [31:0] pick(input int unsigned n);
                pick = $unsigned($random(seed)) % n;
        endfunction

        //////////////////////////////////////////////////////////////////////
        // Stimulus helpers
        //////////////////////////////////////////////////////////////////////

        task automatic issue(input int op, input int rd, input int rs, input int rt,
                        input int imm);
                @(posedge clk);
                instValid <= 1'b1;
                inst.op   <= opCode_t'(op[3:0]);
                inst.rd   <= rd[4:0];
                inst.rs   <= rs[4:0];
                inst.rt   <= rt[4:0];
                inst.imm  <= imm[15:0];
                lastRd = rd[4:0];
        endtask

        // Garbage on inst while the strobe is low
        task automatic idleCycles(input int n);
                for (int i = 0; i < n; i++) begin
                        @(posedge clk);
                        instValid <= 1'b0;
                        inst.imm  <= immWidth'(pick(65536));
                        inst.rs   <= regAddrWidth'(pick(32));
                end
        endtask

        task automatic finishTest();
                int waited;
                @(posedge clk);
                instValid <= 1'b0;
                for (waited = 0; waited < 20; waited++) begin
                        @(posedge clk);
                        if (busy === 1'b0) begin
                                break;
                        end
                end
                if (waited == 20) begin
                        $display("Timeout: results of test %0d still pending", testNum);
                        timedOut = 1'b1;
                end
                testEnd <= 1'b1;
                @(posedge clk);
                testEnd <= 1'b0;
                testNum <= testNum + 4'd1;
        endtask

        //////////////////////////////////////////////////////////////////////
        // Test phases
        //////////////////////////////////////////////////////////////////////

        initial begin
                int i;
                int k;
                clk = 1'b0;
                reset = 1'b1;
                instValid = 1'b0;
                inst = '0;
                testNum = 4'd1;
                testEnd = 1'b0;
                seed = 32'h70ec;
                timedOut = 1'b0;
                lastRd = '0;

                // Valid instructions during reset must leave no trace
                for (i = 0; i < 3; i++) begin
                        @(posedge clk);
                        instValid <= (i < 2);
                        inst.op   <= OP_LI;
                        inst.rd   <= regAddrWidth'(pick(32));
                        inst.imm  <= immWidth'(pick(65536));
                        if (i == 2) begin
                                reset <= 1'b0;
                        end
                end
                for (i = 0; i < 10 && wb !== '0; i++) begin
                        @(posedge clk);
                end
                if (i == 10) begin
                        $display("Timeout: wb never cleared after reset");
                        timedOut = 1'b1;
                end

                // 1: every register reads zero
                for (i = 0; i < 16; i++) begin
                        issue(pick(9), pick(32), pick(32), pick(32), pick(65536));
                end
                finishTest();

                // 2: load-immediate, register zero included
                for (i = 0; i < 24; i++) begin
                        issue(OP_LI, (i < 3) ? 0 : pick(32), 0, 0, pick(65536));
                end
                for (i = 0; i < 24; i++) begin
                        issue(OP_OR, pick(32), (i < 2) ? 0 : pick(32), 0, 0);
                end
                finishTest();

                // 3: ALU ops, register 1 holds a sign-bit value
                for (i = 1; i < 32; i++) begin
                        issue(OP_LI, i, 0, 0, (i == 1) ? 16'h8000 : pick(65536));
                end
                for (k = 0; k < 32; k++) begin
                        issue(OP_LI, 20, 0, 0, (pick(2048) << 5) | k);
                        issue(OP_SRA, 21, 1, 20, 0);
                        issue(OP_SRL, 22, 1, 20, 0);
                end
                for (i = 0; i < 40; i++) begin
                        issue(pick(6), pick(32), pick(32), pick(32), 0);
                end
                finishTest();

                // 4: compares on opposite-sign and equal operands
                issue(OP_LI, 1, 0, 0, 16'h8000);
                issue(OP_LI, 2, 0, 0, 16'h7fff);
                issue(OP_LI, 3, 0, 0, pick(65536));
                issue(OP_OR, 4, 3, 0, 0);
                for (i = 0; i < 40; i++) begin
                        k = pick(5);
                        issue(OP_SLT + pick(3), 8 + pick(24), k, pick(2) ? k : pick(5), 0);
                end
                finishTest();

                // 5: back-to-back with sources naming the last destination
                for (i = 0; i < 80; i++) begin
                        issue(pick(10), pick(32), pick(4) ? lastRd : pick(32),
                                pick(2) ? lastRd : pick(32), pick(65536));
                end
                finishTest();

                // 6: idle gaps and undefined codes
                for (i = 0; i < 60; i++) begin
                        idleCycles(pick(4));
                        issue(pick(2) ? 10 + pick(6) : pick(10), pick(32),
                                pick(2) ? lastRd : pick(32), pick(32), pick(65536));
                end
                finishTest();

                @(negedge clk);
                $display("Totals: %0d checked, %0d monitor errors, %0d assertion failures, %0s",
                        checkCount, errorCount, u_execCore.u_chk.failCount,
                        timedOut ? "timed out" : "no timeout");
                if (timedOut || errorCount != 0 || u_execCore.u_chk.failCount != 0) begin
                        $display("Some tests failed");
                end else begin
                        $display("All tests passed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: project.f
verilog/execPkg.sv
verilog/regFile.sv
verilog/alu.sv
verilog/compareUnit.sv
verilog/resultSelect.sv
verilog/execCore.sv
tests/execCore_chk.sv
tests/execCoreMonitor.sv
tests/execCore_tb.sv
